// ==== filelist.f ====
+incdir+.
bpuPkg.sv
resolveIf.sv
targetTable.sv
returnStack.sv
predictStage.sv
branchPredictor.sv
branchPredictorTb.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - include_dirs:
      - .
    files:
      - bpuPkg.sv
      - resolveIf.sv
      - targetTable.sv
      - returnStack.sv
      - predictStage.sv
      - branchPredictor.sv
      - target: simulation
        files:
          - branchPredictorTb.sv

// ==== branchPredictorTb.sv ====
// testbench for the branch prediction unit with reference model and random traffic
`timescale 1ns/1ps
`include "bpu_macros.svh"

module branchPredictorTb;

    localparam int ClkPeriod      = 4;
    localparam int ResetCycles    = 3;
    localparam int DirectedCycles = 64;
    localparam int RandomCycles   = 3000;
    localparam int TimeoutNs      =
        (ResetCycles + DirectedCycles + RandomCycles + 100) * ClkPeriod;
    localparam int Entries = 1 << `BPU_INDEX_BITS;

    logic               clk;
    logic               rstN;
    logic               ifWr;
    logic               ifFlush;
    bpuPkg::addrT       preIfPc;
    logic               resValid;
    bpuPkg::addrT       resPc;
    bpuPkg::addrT       resTarget;
    bpuPkg::branchTypeE resType;
    logic               resIsTaken;
    logic               resHit;
    bpuPkg::countT      resCount;
    logic               idIsBranch;
    bpuPkg::addrT       predTarget;
    logic               predIsTaken;
    bpuPkg::branchTypeE predType;
    bpuPkg::countT      predCount;
    logic               predHit;
    logic               predValid;

    // reference copies of table, stack and prediction register
    bpuPkg::tableEntryT modelTable [0:Entries-1];
    bpuPkg::rasEntryT   modelStack [0:`BPU_RAS_DEPTH-1];
    logic [2:0]         modelPtr;
    logic               mValid;
    bpuPkg::tagT        mTag;
    bpuPkg::tagT        mPcTag;
    bpuPkg::addrT       mTarget;
    bpuPkg::addrT       mPcAdd8;
    bpuPkg::branchTypeE mType;
    bpuPkg::countT      mCount;
    bpuPkg::rasEntryT   mRas;
    logic [31:0]        lfsrState;
    bpuPkg::predRecordT expected;

    branchPredictor dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // galois step per bit with taps of x^32+x^22+x^2+x+1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // few tags and indices so hits and aliasing both happen
    function automatic bpuPkg::addrT poolAddr();
        bpuPkg::addrT a;
        a = randBits(2) << `BPU_TAG_LSB;
        a = a | (randBits(2) << `BPU_INDEX_LSB);
        return a;
    endfunction

    // model update at one rising edge
    function automatic void applyEdge();
        bpuPkg::rasEntryT   top;
        bpuPkg::tableEntryT seen;
        logic [2:0]         below;
        int                 c;
        below = modelPtr - 3'd1;
        top   = modelStack[below];
        if (resValid && resType == bpuPkg::brCall) begin
            top = '{valid: 1'b1, addr: resPc + 8};
        end
        // flush has priority over a capture
        if (!rstN || ifFlush) begin
            mValid  = 1'b0;
            mTag    = '0;
            mPcTag  = '0;
            mTarget = '0;
            mType   = bpuPkg::brNone;
            mCount  = '0;
            mRas    = '0;
            mPcAdd8 = 32'd8;
        end else if (ifWr) begin
            seen    = modelTable[preIfPc[`BPU_TAG_LSB-1:`BPU_INDEX_LSB]];
            mValid  = 1'b1;
            mTag    = seen.tag;
            mTarget = seen.target;
            mType   = seen.brType;
            mCount  = seen.count;
            mPcTag  = preIfPc[`BPU_ADDR_BITS-1:`BPU_TAG_LSB];
            mPcAdd8 = preIfPc + 8;
            mRas    = top;
        end
        // table and stack take every resolution even during a flush
        if (!rstN) begin
            for (int i = 0; i < Entries; i++) begin
                modelTable[i] = '0;
            end
            for (int i = 0; i < `BPU_RAS_DEPTH; i++) begin
                modelStack[i] = '0;
            end
            modelPtr = '0;
        end else if (resValid) begin
            c = resCount;
            if (!resHit) c = resIsTaken ? 2 : 1;
            else if (resIsTaken) c = (c < 3) ? c + 1 : 3;
            else c = (c > 0) ? c - 1 : 0;
            modelTable[resPc[`BPU_TAG_LSB-1:`BPU_INDEX_LSB]] = '{
                tag: resPc[`BPU_ADDR_BITS-1:`BPU_TAG_LSB], target: resTarget,
                brType: resType, count: c[1:0]};
            if (resType == bpuPkg::brCall) begin
                modelStack[modelPtr] = '{valid: 1'b1, addr: resPc + 8};
                modelPtr = modelPtr + 3'd1;
            end else if (resType == bpuPkg::brRet) begin
                modelPtr = below;
            end
        end
    endfunction

    // expected outputs from the model register
    function automatic bpuPkg::predRecordT predictRef(input logic idBr);
        bpuPkg::predRecordT r;
        r.valid   = mValid & ~idBr;
        r.hit     = (mTag == mPcTag);
        r.count   = mCount;
        r.brType  = r.hit ? mType : bpuPkg::brNone;
        r.target  = mPcAdd8;
        r.isTaken = 1'b0;
        if (r.hit && (mType == bpuPkg::brJump || mType == bpuPkg::brCall ||
                (mType == bpuPkg::brBranch && mCount >= 2))) begin
            r.target  = mTarget;
            r.isTaken = 1'b1;
        end else if (r.hit && mType == bpuPkg::brRet) begin
            r.isTaken = 1'b1;
            if (mRas.valid) r.target = mRas.addr;
        end
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] exp);
        if (actual !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, exp);
            $display("Simulation failed");
            $fatal(1, "output check failed");
        end
    endtask

    // compare 3 ns after the edge, once inputs and outputs have settled
    initial begin
        forever begin
            @(posedge clk);
            applyEdge();
            #3;
            expected = predictRef(idIsBranch);
            checkValue("predValid", predValid, expected.valid);
            checkValue("predHit", predHit, expected.hit);
            checkValue("predType", predType, expected.brType);
            checkValue("predCount", predCount, expected.count);
            checkValue("predIsTaken", predIsTaken, expected.isTaken);
            checkValue("predTarget", predTarget, expected.target);
        end
    end

    initial begin
        #(TimeoutNs);
        $display("timeout: the stimulus did not complete within %0d ns", TimeoutNs);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    task automatic tick();
        @(posedge clk);
        #1;
        ifWr     = 1'b0;
        ifFlush  = 1'b0;
        resValid = 1'b0;
    endtask

    // hit and count come from what the table held for this pc
    task automatic setResolve(input bpuPkg::addrT pc, input bpuPkg::addrT target,
                              input bpuPkg::branchTypeE brType, input logic taken);
        bpuPkg::tableEntryT seen;
        seen       = modelTable[pc[`BPU_TAG_LSB-1:`BPU_INDEX_LSB]];
        resValid   = 1'b1;
        resPc      = pc;
        resTarget  = target;
        resType    = brType;
        resIsTaken = taken;
        resHit     = (seen.tag == pc[`BPU_ADDR_BITS-1:`BPU_TAG_LSB]);
        resCount   = seen.count;
    endtask

    task automatic resolve(input bpuPkg::addrT pc, input bpuPkg::addrT target,
                           input bpuPkg::branchTypeE brType, input logic taken);
        setResolve(pc, target, brType, taken);
        tick();
    endtask

    task automatic fetch(input bpuPkg::addrT pc);
        preIfPc = pc;
        ifWr    = 1'b1;
        tick();
    endtask

    initial begin
        lfsrState  = 32'h874a6058;
        rstN       = 1'b0;
        {ifWr, ifFlush, resValid, resIsTaken, resHit, idIsBranch} = '0;
        {preIfPc, resPc, resTarget, resCount} = '0;
        resType    = bpuPkg::brNone;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        // cold miss, then branch training through all counter values
        fetch(32'h0000_1a14);
        for (int i = 0; i < 8; i++) begin
            resolve(32'h0000_1a14, 32'h0000_8000, bpuPkg::brBranch, i < 4);
            fetch(32'h0000_1a14);
        end
        // jump, call and an aliasing miss
        resolve(32'h0000_2020, 32'h0000_9000, bpuPkg::brJump, 1'b1);
        fetch(32'h0000_2020);
        resolve(32'h0000_3040, 32'h0000_a000, bpuPkg::brCall, 1'b1);
        fetch(32'h0000_3040);
        fetch(32'h0000_5020);
        // return on an empty slot, nested calls, then the capture bypass
        resolve(32'h0000_40c0, 32'h0, bpuPkg::brRet, 1'b1);
        fetch(32'h0000_40c0);
        resolve(32'h0000_3040, 32'h0000_a000, bpuPkg::brCall, 1'b1);
        resolve(32'h0000_3180, 32'h0000_b000, bpuPkg::brCall, 1'b1);
        fetch(32'h0000_40c0);
        resolve(32'h0000_40c0, 32'h0, bpuPkg::brRet, 1'b1);
        fetch(32'h0000_40c0);
        setResolve(32'h0000_6100, 32'h0000_c000, bpuPkg::brCall, 1'b1);
        fetch(32'h0000_40c0);
        // flush beats capture, decode branch hides valid, hold without ifWr
        ifFlush = 1'b1;
        fetch(32'h0000_2020);
        fetch(32'h0000_2020);
        idIsBranch = 1'b1;
        tick();
        idIsBranch = 1'b0;
        preIfPc    = 32'h0000_3040;
        repeat (3) tick();
        for (int i = 0; i < RandomCycles; i++) begin
            ifWr       = randBits(1);
            ifFlush    = (randBits(3) == 3'd7);
            preIfPc    = poolAddr();
            resValid   = randBits(1);
            resPc      = poolAddr();
            resTarget  = randBits(30) << 2;
            resType    = bpuPkg::branchTypeE'(randBits(3) % 5);
            resIsTaken = randBits(1);
            resHit     = randBits(1);
            resCount   = randBits(2);
            idIsBranch = (randBits(2) == 2'd0);
            tick();
        end
        tick();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== branchPredictor.sv ====
// branch prediction unit top with target table, return stack and prediction stage
`timescale 1ns/1ps

module branchPredictor (
    input  logic               clk,
    input  logic               rstN,
    input  logic               ifWr,
    input  logic               ifFlush,
    input  bpuPkg::addrT       preIfPc,
    input  logic               resValid,
    input  bpuPkg::addrT       resPc,
    input  bpuPkg::addrT       resTarget,
    input  bpuPkg::branchTypeE resType,
    input  logic               resIsTaken,
    input  logic               resHit,
    input  bpuPkg::countT      resCount,
    input  logic               idIsBranch,
    output bpuPkg::addrT       predTarget,
    output logic               predIsTaken,
    output bpuPkg::branchTypeE predType,
    output bpuPkg::countT      predCount,
    output logic               predHit,
    output logic               predValid
);

    bpuPkg::tableEntryT readEntry;
    bpuPkg::rasEntryT   rasTop;

    resolveIf resBus ();

    // execute stage record onto the shared bundle
    assign resBus.valid   = resValid;
    assign resBus.pc      = resPc;
    assign resBus.target  = resTarget;
    assign resBus.brType  = resType;
    assign resBus.isTaken = resIsTaken;
    assign resBus.hit     = resHit;
    assign resBus.count   = resCount;

    targetTable table_i (
        .clk       (clk),
        .rstN      (rstN),
        .readPc    (preIfPc),
        .res       (resBus.sink),
        .readEntry (readEntry)
    );

    returnStack ras_i (
        .clk      (clk),
        .rstN     (rstN),
        .res      (resBus.sink),
        .topEntry (rasTop)
    );

    predictStage predict_i (
        .clk         (clk),
        .rstN        (rstN),
        .ifWr        (ifWr),
        .ifFlush     (ifFlush),
        .preIfPc     (preIfPc),
        .readEntry   (readEntry),
        .rasTop      (rasTop),
        .idIsBranch  (idIsBranch),
        .predTarget  (predTarget),
        .predIsTaken (predIsTaken),
        .predType    (predType),
        .predCount   (predCount),
        .predHit     (predHit),
        .predValid   (predValid)
    );

endmodule

// ==== predictStage.sv ====
// prediction register with hit check and next fetch target selection
`timescale 1ns/1ps
`include "bpu_macros.svh"

module predictStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               ifWr,
    input  logic               ifFlush,
    input  bpuPkg::addrT       preIfPc,
    input  bpuPkg::tableEntryT readEntry,
    input  bpuPkg::rasEntryT   rasTop,
    input  logic               idIsBranch,
    output bpuPkg::addrT       predTarget,
    output logic               predIsTaken,
    output bpuPkg::branchTypeE predType,
    output bpuPkg::countT      predCount,
    output logic               predHit,
    output logic               predValid
);

    logic               regValid;
    bpuPkg::tagT        regTag;
    bpuPkg::tagT        regPcTag;
    bpuPkg::addrT       regTarget;
    bpuPkg::addrT       regPcAdd8;
    bpuPkg::branchTypeE regType;
    bpuPkg::countT      regCount;
    bpuPkg::rasEntryT   regRas;
    logic               tagHit;
    bpuPkg::predRecordT rec;

    // flush has priority over a capture in the same cycle
    always_ff @(posedge clk) begin
        if (!rstN || ifFlush) begin
            regValid  <= 1'b0;
            regTag    <= '0;
            regPcTag  <= '0;
            regTarget <= '0;
            regPcAdd8 <= 32'd8;
            regType   <= bpuPkg::brNone;
            regCount  <= '0;
            regRas    <= '0;
        end else if (ifWr) begin
            regValid  <= 1'b1;
            regTag    <= readEntry.tag;
            regPcTag  <= preIfPc[`BPU_ADDR_BITS-1:`BPU_TAG_LSB];
            regTarget <= readEntry.target;
            regPcAdd8 <= preIfPc + 32'd8;
            regType   <= readEntry.brType;
            regCount  <= readEntry.count;
            regRas    <= rasTop;
        end
    end

    assign tagHit = (regTag == regPcTag);

    always_comb begin
        rec.valid  = regValid && !idIsBranch;
        rec.hit    = tagHit;
        rec.brType = tagHit ? regType : bpuPkg::brNone;
        rec.count  = regCount;
        if (!tagHit) begin
            rec.target  = regPcAdd8;
            rec.isTaken = 1'b0;
        end else begin
            case (regType)
                bpuPkg::brJump, bpuPkg::brCall: begin
                    rec.target  = regTarget;
                    rec.isTaken = 1'b1;
                end
                bpuPkg::brBranch: begin
                    // upper counter bit gives the direction
                    rec.target  = regCount[1] ? regTarget : regPcAdd8;
                    rec.isTaken = regCount[1];
                end
                bpuPkg::brRet: begin
                    // empty stack still redirects, just sequentially
                    rec.target  = regRas.valid ? regRas.addr : regPcAdd8;
                    rec.isTaken = 1'b1;
                end
                default: begin
                    rec.target  = regPcAdd8;
                    rec.isTaken = 1'b0;
                end
            endcase
        end
    end

    assign predValid   = rec.valid;
    assign predHit     = rec.hit;
    assign predType    = rec.brType;
    assign predCount   = rec.count;
    assign predIsTaken = rec.isTaken;
    assign predTarget  = rec.target;

endmodule

// ==== returnStack.sv ====
// circular return address stack pushed by calls and popped by returns
`timescale 1ns/1ps
`include "bpu_macros.svh"

module returnStack (
    input  logic             clk,
    input  logic             rstN,
    resolveIf.sink           res,
    output bpuPkg::rasEntryT topEntry
);

    localparam int PtrBits = $clog2(`BPU_RAS_DEPTH);

    bpuPkg::rasEntryT   stack [0:`BPU_RAS_DEPTH-1];
    logic [PtrBits-1:0] topPtr;
    logic [PtrBits-1:0] belowPtr;
    logic               push;
    logic               pop;
    bpuPkg::addrT       pushAddr;

    // pointer names the next free slot, wraps on overflow
    assign belowPtr = topPtr - 1'b1;

    assign push     = res.valid && (res.brType == bpuPkg::brCall);
    assign pop      = res.valid && (res.brType == bpuPkg::brRet);
    // return lands after the call and its delay slot
    assign pushAddr = res.pc + 32'd8;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            topPtr <= '0;
            for (int i = 0; i < `BPU_RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
        end else if (push) begin
            stack[topPtr].valid <= 1'b1;
            stack[topPtr].addr  <= pushAddr;
            topPtr              <= topPtr + 1'b1;
        end else if (pop) begin
            topPtr <= belowPtr;
        end
    end

    // bypass so a capture in the push cycle already sees the new return
    always_comb begin
        if (push) begin
            topEntry.valid = 1'b1;
            topEntry.addr  = pushAddr;
        end else begin
            topEntry = stack[belowPtr];
        end
    end

endmodule

// ==== targetTable.sv ====
// direct-mapped branch target table with combinational read and resolution write
`timescale 1ns/1ps
`include "bpu_macros.svh"

module targetTable (
    input  logic               clk,
    input  logic               rstN,
    input  bpuPkg::addrT       readPc,
    resolveIf.sink             res,
    output bpuPkg::tableEntryT readEntry
);

    localparam int Entries = 1 << `BPU_INDEX_BITS;

    bpuPkg::tableEntryT entries [0:Entries-1];
    bpuPkg::indexT      readIndex;
    bpuPkg::indexT      writeIndex;
    bpuPkg::tableEntryT writeEntry;
    bpuPkg::countT      nextCount;

    assign readIndex  = readPc[`BPU_TAG_LSB-1:`BPU_INDEX_LSB];
    assign writeIndex = res.pc[`BPU_TAG_LSB-1:`BPU_INDEX_LSB];

    // read is asynchronous, a same-cycle write is seen after the edge
    assign readEntry = entries[readIndex];

    // saturating counter update
    always_comb begin
        if (res.hit) begin
            if (res.isTaken) begin
                if (res.count == 2'd3) begin
                    nextCount = 2'd3;
                end else begin
                    nextCount = res.count + 2'd1;
                end
            end else begin
                if (res.count == 2'd0) begin
                    nextCount = 2'd0;
                end else begin
                    nextCount = res.count - 2'd1;
                end
            end
        end else begin
            // fresh entry starts weakly in the resolved direction
            if (res.isTaken) begin
                nextCount = 2'd2;
            end else begin
                nextCount = 2'd1;
            end
        end
    end

    always_comb begin
        writeEntry.tag    = res.pc[`BPU_ADDR_BITS-1:`BPU_TAG_LSB];
        writeEntry.target = res.target;
        writeEntry.brType = res.brType;
        writeEntry.count  = nextCount;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < Entries; i++) begin
                entries[i] <= '0;
            end
        end else if (res.valid) begin
            // every resolution overwrites its slot, aliasing included
            entries[writeIndex] <= writeEntry;
        end
    end

endmodule

// ==== resolveIf.sv ====
// execute stage branch resolution record, one record per valid strobe
`timescale 1ns/1ps

interface resolveIf;

    logic               valid;
    bpuPkg::addrT       pc;
    bpuPkg::addrT       target;
    bpuPkg::branchTypeE brType;
    logic               isTaken;
    // hit and count as they were predicted at fetch
    logic               hit;
    bpuPkg::countT      count;

    modport source (
        output valid, pc, target, brType, isTaken, hit, count
    );

    modport sink (
        input valid, pc, target, brType, isTaken, hit, count
    );

endinterface

// ==== bpuPkg.sv ====
// branch predictor types for addresses, table entries, stack entries and records
`include "bpu_macros.svh"

package bpuPkg;

    typedef logic [`BPU_ADDR_BITS-1:0] addrT;
    typedef logic [`BPU_ADDR_BITS-`BPU_TAG_LSB-1:0] tagT;
    typedef logic [`BPU_INDEX_BITS-1:0] indexT;

    // 0,1 not taken and 2,3 taken
    typedef logic [1:0] countT;

    // none must stay zero so a cleared entry never predicts taken
    typedef enum logic [2:0] {
        brNone   = 3'd0,
        brBranch = 3'd1,
        brJump   = 3'd2,
        brCall   = 3'd3,
        brRet    = 3'd4
    } branchTypeE;

    typedef struct packed {
        tagT        tag;
        addrT       target;
        branchTypeE brType;
        countT      count;
    } tableEntryT;

    typedef struct packed {
        logic valid;
        addrT addr;
    } rasEntryT;

    typedef struct packed {
        logic       valid;
        logic       hit;
        branchTypeE brType;
        countT      count;
        logic       isTaken;
        addrT       target;
    } predRecordT;

endpackage

// ==== bpu_macros.svh ====
// branch predictor sizing constants shared by the package and the RTL
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// index bits into the target table, entries = 2**index
`define BPU_INDEX_BITS 6

// return address stack entries, power of two so the pointer wraps
`define BPU_RAS_DEPTH 8

// fetch and target address width
`define BPU_ADDR_BITS 32

// index sits right above the two byte offset bits
`define BPU_INDEX_LSB 2
`define BPU_TAG_LSB (`BPU_INDEX_BITS + `BPU_INDEX_LSB)

`endif
